// File: mult_disp_top.f
design/mult_disp_pkg.sv
design/pp_wallace_stage.sv
design/cpa_stage.sv
design/seg_encode_stage.sv
design/mult_disp_top.sv
tests/mult_disp_props.sv
tests/mult_disp_tb.sv

// File: Bender.yml
package:
  name: mult_disp

sources:
  # Synthesizable design, package first
  - files:
      - design/mult_disp_pkg.sv
      - design/pp_wallace_stage.sv
      - design/cpa_stage.sv
      - design/seg_encode_stage.sv
      - design/mult_disp_top.sv

  # Verification only
  - target: test
    files:
      - tests/mult_disp_props.sv
      - tests/mult_disp_tb.sv

// File: tests/mult_disp_tb.sv
// Drives the multiplier from fixed-delay stimulus; the scoreboard covers product only, props check the rest
`timescale 1ns/1ns
`default_nettype none

module mult_disp_tb;

    import mult_disp_pkg::*;

    // Run lengths
    localparam int RESET_CYCLES  = 5;
    localparam int SWEEP_PAIRS   = 256;  // Every a, b pair once
    localparam int RANDOM_CYCLES = 200;
    localparam int IDLE_CYCLES   = 8;    // Pipeline drain and hold check

    // Reset, sweep, random and idle come to about 470 cycles
    localparam int TIMEOUT_CYCLES = 600;

    localparam logic [31:0] SEED = 32'hcafb_c123;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     in_valid;
    operand_t a;
    operand_t b;
    logic     blank_lead;

    wire           out_valid;
    wire product_t product;
    wire seg_t     seg_hi_n;
    wire seg_t     seg_lo_n;

    product_t    expected_q [$];  // Products still in flight
    int unsigned error_count = 0;
    int unsigned cycle_count = 0;

    always #5 clk = ~clk;

    mult_disp_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .a          (a),
        .b          (b),
        .blank_lead (blank_lead),
        .out_valid  (out_valid),
        .product    (product),
        .seg_hi_n   (seg_hi_n),
        .seg_lo_n   (seg_lo_n)
    );

    // One sample, set up 1 ns after the rising edge
    task automatic drive_inputs(
        input logic     valid,
        input operand_t op_a,
        input operand_t op_b,
        input logic     blank
    );
        @(posedge clk);
        #1;
        in_valid   = valid;
        a          = op_a;
        b          = op_b;
        blank_lead = blank;
    endtask

    // Inputs and outputs are both settled at the falling edge
    always @(negedge clk) begin : scoreboard
        product_t expected;
        if (rst_n && dut.prod_valid) begin
            if (expected_q.size() == 0) begin
                error_count++;
                $display("Scoreboard saw a valid product at %0t with no sample pending", $time);
            end else begin
                expected = expected_q.pop_front();
                if (product !== expected) begin
                    error_count++;
                    $display("FAILED at %0t: product %0h, expected %0h",
                             $time, product, expected);
                end
            end
        end
        // Pushed after the pop, latency is at least one cycle
        if (rst_n && in_valid) begin
            expected_q.push_back(product_t'(a) * product_t'(b));
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] rnd;
        rnd        = $urandom(SEED);
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        a          = '0;
        b          = '0;
        blank_lead = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Exhaustive sweep, back to back
        for (int i = 0; i < SWEEP_PAIRS; i++) begin
            drive_inputs(1'b1, operand_t'(i >> 4), operand_t'(i), i[0]);
        end

        // Random gaps, operands and blanking
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            rnd = $urandom;
            drive_inputs(rnd[0], rnd[7:4], rnd[11:8], rnd[12]);
        end

        // Operands keep moving while in_valid is low
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            rnd = $urandom;
            drive_inputs(1'b0, rnd[7:4], rnd[11:8], rnd[12]);
        end

        while (expected_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);  // Last digits settle

        $display("Summary: %0d scoreboard errors, %0d assertion failures",
                 error_count, dut.u_props.fail_count);
        if (error_count == 0 && dut.u_props.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : mult_disp_tb

`default_nettype wire

// File: tests/mult_disp_props.sv
// Expects the synchronous reset and three one-cycle stages; segments active low, bit 6 is a
`timescale 1ns/1ns
`default_nettype none

module mult_disp_props (
    input wire                          clk,
    input wire                          rst_n,
    input wire                          in_valid,
    input wire mult_disp_pkg::operand_t a,
    input wire mult_disp_pkg::operand_t b,
    input wire                          blank_lead,
    input wire                          out_valid,
    input wire mult_disp_pkg::product_t product,
    input wire mult_disp_pkg::seg_t     seg_hi_n,
    input wire mult_disp_pkg::seg_t     seg_lo_n
);

    import mult_disp_pkg::*;

    int unsigned fail_count = 0;
    logic        shown;  // Some digit pattern has been presented since reset

    // Reference hex font, low means lit
    function automatic seg_t digit_pattern(input logic [3:0] nib);
        case (nib)
            4'h0:    return 7'b0000001;
            4'h1:    return 7'b1001111;
            4'h2:    return 7'b0010010;
            4'h3:    return 7'b0000110;
            4'h4:    return 7'b1001100;
            4'h5:    return 7'b0100100;
            4'h6:    return 7'b0100000;
            4'h7:    return 7'b0001111;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0000100;
            4'ha:    return 7'b0001000;
            4'hb:    return 7'b1100000;
            4'hc:    return 7'b0110001;
            4'hd:    return 7'b1000010;
            4'he:    return 7'b0110000;
            default: return 7'b0111000;
        endcase
    endfunction

    function automatic seg_t upper_pattern(input logic [3:0] nib, input logic blank);
        if (blank && nib == 4'h0) begin
            return '1;  // Leading zero dark
        end
        return digit_pattern(nib);
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shown <= 1'b0;
        end else if (out_valid) begin
            shown <= 1'b1;
        end
    end

    dark_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        (!shown && !out_valid) |-> (seg_hi_n == '1 && seg_lo_n == '1))
    else begin
        fail_count++;
        $error("Digits lit before the first valid result");
    end

    valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == ($past(in_valid, 3) && $past(rst_n, 1) && $past(rst_n, 2) && $past(rst_n, 3)))
    else begin
        fail_count++;
        $error("out_valid does not follow in_valid by three cycles");
    end

    product_value: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(in_valid, 2) && $past(rst_n, 1) && $past(rst_n, 2)) |->
        product == {4'h0, $past(a, 2)} * {4'h0, $past(b, 2)})
    else begin
        fail_count++;
        $error("product differs from a * b two cycles earlier");
    end

    low_digit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> seg_lo_n == digit_pattern($past(product[3:0])))
    else begin
        fail_count++;
        $error("Lower digit pattern wrong");
    end

    high_digit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> seg_hi_n == upper_pattern($past(product[7:4]), $past(blank_lead)))
    else begin
        fail_count++;
        $error("Upper digit pattern or blanking wrong");
    end

    product_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (!$past(in_valid, 2) && $past(rst_n)) |-> product == $past(product))
    else begin
        fail_count++;
        $error("product changed without a valid sample");
    end

    digits_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (!$past(in_valid, 3) && $past(rst_n)) |->
        (seg_hi_n == $past(seg_hi_n) && seg_lo_n == $past(seg_lo_n)))
    else begin
        fail_count++;
        $error("Digits changed without a valid sample");
    end

endmodule : mult_disp_props

bind mult_disp_top mult_disp_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .a          (a),
    .b          (b),
    .blank_lead (blank_lead),
    .out_valid  (out_valid),
    .product    (product),
    .seg_hi_n   (seg_hi_n),
    .seg_lo_n   (seg_lo_n)
);

`default_nettype wire

// File: design/mult_disp_top.sv
// Digits lag a sample by three cycles, product by two; no back-pressure, take outputs each cycle
`timescale 1ns/1ns
`default_nettype none

module mult_disp_top (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           in_valid,
    input  wire mult_disp_pkg::operand_t  a,
    input  wire mult_disp_pkg::operand_t  b,
    input  wire                           blank_lead,
    output wire                           out_valid,
    output wire mult_disp_pkg::product_t  product,
    output wire mult_disp_pkg::seg_t      seg_hi_n,
    output wire mult_disp_pkg::seg_t      seg_lo_n
);

    import mult_disp_pkg::*;

    // Stage one to stage two
    wire       row_valid;
    wire row_t sum_row;
    wire row_t carry_row;

    wire prod_valid;  // Stage two to stage three

    // Partial products and carry-save tree
    pp_wallace_stage u_pp (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .row_valid (row_valid),
        .sum_row   (sum_row),
        .carry_row (carry_row)
    );

    // Final addition, product also leaves the chip here
    cpa_stage u_cpa (
        .clk        (clk),
        .rst_n      (rst_n),
        .row_valid  (row_valid),
        .sum_row    (sum_row),
        .carry_row  (carry_row),
        .prod_valid (prod_valid),
        .product    (product)
    );

    seg_encode_stage u_seg (
        .clk        (clk),
        .rst_n      (rst_n),
        .prod_valid (prod_valid),
        .product    (product),
        .blank_lead (blank_lead),  // Sampled with the product it applies to
        .out_valid  (out_valid),
        .seg_hi_n   (seg_hi_n),
        .seg_lo_n   (seg_lo_n)
    );

endmodule : mult_disp_top

`default_nettype wire

// File: design/seg_encode_stage.sv
// Active-low segments, bit 6 is a; blank_lead must be valid in the same cycle as prod_valid
`timescale 1ns/1ns
`default_nettype none

module seg_encode_stage (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           prod_valid,
    input  wire mult_disp_pkg::product_t  product,
    input  wire                           blank_lead,
    output logic                          out_valid,
    output mult_disp_pkg::seg_t           seg_hi_n,
    output mult_disp_pkg::seg_t           seg_lo_n
);

    import mult_disp_pkg::*;

    seg_t hi_pattern;
    seg_t lo_pattern;
    logic hi_is_zero;

    // Hex digit to {a,b,c,d,e,f,g}, low means lit
    function automatic seg_t hex_seg(input logic [PRODUCT_W/2-1:0] nib);
        seg_t seg;
        case (nib)
            4'h0:    seg = 7'b0000001;
            4'h1:    seg = 7'b1001111;
            4'h2:    seg = 7'b0010010;
            4'h3:    seg = 7'b0000110;
            4'h4:    seg = 7'b1001100;
            4'h5:    seg = 7'b0100100;
            4'h6:    seg = 7'b0100000;
            4'h7:    seg = 7'b0001111;
            4'h8:    seg = 7'b0000000;
            4'h9:    seg = 7'b0000100;
            4'ha:    seg = 7'b0001000;
            4'hb:    seg = 7'b1100000;  // Lower case b
            4'hc:    seg = 7'b0110001;
            4'hd:    seg = 7'b1000010;  // Lower case d
            4'he:    seg = 7'b0110000;
            default: seg = 7'b0111000;  // F
        endcase
        return seg;
    endfunction

    assign hi_is_zero = (product[PRODUCT_W-1:PRODUCT_W/2] == '0);

    always_comb begin
        lo_pattern = hex_seg(product[PRODUCT_W/2-1:0]);
        // Leading zero only blanks the upper digit, never the lower one
        if (blank_lead && hi_is_zero) begin
            hi_pattern = '1;
        end else begin
            hi_pattern = hex_seg(product[PRODUCT_W-1:PRODUCT_W/2]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            seg_hi_n  <= '1;  // Both digits dark
            seg_lo_n  <= '1;
        end else begin
            out_valid <= prod_valid;
            if (prod_valid) begin
                seg_hi_n <= hi_pattern;
                seg_lo_n <= lo_pattern;
            end
        end
    end

endmodule : seg_encode_stage

`default_nettype wire

// File: design/cpa_stage.sv
// Carry out of bit 7 is not kept; rows must come from a 4x4 unsigned product
`timescale 1ns/1ns
`default_nettype none

module cpa_stage (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        row_valid,
    input  wire mult_disp_pkg::row_t   sum_row,
    input  wire mult_disp_pkg::row_t   carry_row,
    output logic                       prod_valid,
    output mult_disp_pkg::product_t    product
);

    import mult_disp_pkg::*;

    logic [PRODUCT_W-1:0] ripple;  // Carry into each bit
    product_t             sum_comb;

    // Ripple carry chain, then the sum bits
    always_comb begin
        ripple[0] = 1'b0;
        for (int i = 0; i < PRODUCT_W - 1; i++) begin
            ripple[i+1] = (sum_row[i] & carry_row[i]) |
                          (sum_row[i] & ripple[i])    |
                          (carry_row[i] & ripple[i]);
        end
        for (int i = 0; i < PRODUCT_W; i++) begin
            sum_comb[i] = sum_row[i] ^ carry_row[i] ^ ripple[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            product    <= '0;
        end else begin
            prod_valid <= row_valid;
            if (row_valid) begin
                product <= sum_comb;  // Held until the next valid rows
            end
        end
    end

endmodule : cpa_stage

`default_nettype wire

// File: design/pp_wallace_stage.sv
// Hand-built tree for exactly four partial products; unsigned operands only, one cycle latency
`timescale 1ns/1ns
`default_nettype none

module pp_wallace_stage (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          in_valid,
    input  wire mult_disp_pkg::operand_t a,
    input  wire mult_disp_pkg::operand_t b,
    output logic                         row_valid,
    output mult_disp_pkg::row_t          sum_row,
    output mult_disp_pkg::row_t          carry_row
);

    import mult_disp_pkg::*;

    row_t pp_row [OPERAND_W];  // Shifted partial products
    row_t l1_sum;              // First carry-save layer
    row_t l1_carry;
    row_t l2_sum;              // Second carry-save layer, into the registers
    row_t l2_carry;

    // Column-wise full adders, sum bits
    function automatic row_t csa_sum(input row_t x, input row_t y, input row_t z);
        row_t s;
        for (int i = 0; i < PRODUCT_W; i++) begin
            s[i] = x[i] ^ y[i] ^ z[i];
        end
        return s;
    endfunction

    // Column-wise full adders, carry bits already moved up one column.
    // The carry out of the top column is always zero for this product size.
    function automatic row_t csa_carry(input row_t x, input row_t y, input row_t z);
        row_t c;
        c[0] = 1'b0;
        for (int i = 0; i < PRODUCT_W - 1; i++) begin
            c[i+1] = (x[i] & y[i]) | (x[i] & z[i]) | (y[i] & z[i]);
        end
        return c;
    endfunction

    // Partial product i is a gated by b[i], weighted by 2^i
    always_comb begin
        for (int i = 0; i < OPERAND_W; i++) begin
            pp_row[i] = b[i] ? row_t'(a) << i : '0;
        end
    end

    // Layer one takes pp0, pp1 and pp2
    always_comb begin
        l1_sum   = csa_sum(pp_row[0], pp_row[1], pp_row[2]);
        l1_carry = csa_carry(pp_row[0], pp_row[1], pp_row[2]);
    end

    // Layer two folds in pp3, leaving two rows
    always_comb begin
        l2_sum   = csa_sum(l1_sum, l1_carry, pp_row[3]);
        l2_carry = csa_carry(l1_sum, l1_carry, pp_row[3]);
    end

    // Stage register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_valid <= 1'b0;
            sum_row   <= '0;
            carry_row <= '0;
        end else begin
            row_valid <= in_valid;
            if (in_valid) begin  // Rows hold between samples
                sum_row   <= l2_sum;
                carry_row <= l2_carry;
            end
        end
    end

endmodule : pp_wallace_stage

`default_nettype wire

// File: design/mult_disp_pkg.sv
// Widths are fixed for unsigned 4x4 operands; the Wallace tree does not rescale with OPERAND_W
`default_nettype none

package mult_disp_pkg;

    // Operand and product widths
    localparam int OPERAND_W = 4;
    localparam int PRODUCT_W = 2 * OPERAND_W;  // 15 * 15 = 225 fits in 8 bits

    // Segment count of one display digit
    localparam int SEG_W = 7;

    // One multiplier input
    typedef logic [OPERAND_W-1:0] operand_t;

    // Full unsigned product
    typedef logic [PRODUCT_W-1:0] product_t;

    // One carry-save row of the reduction tree.
    // Same width as the product: the row sum never exceeds 225, so no carry
    // can leave bit 7 of any row.
    typedef logic [PRODUCT_W-1:0] row_t;

    // Active-low digit pattern
    // Bit 6 is segment a, bit 0 is segment g
    typedef logic [SEG_W-1:0] seg_t;

endpackage : mult_disp_pkg

`default_nettype wire
